// File: source/l2_cache_pkg.sv
/*
 * Shared widths, field positions and types for the L2 cache.
 * Every RTL block and the testbench import this package by wildcard.
 */
package l2_cache_pkg;

	typedef logic [11:0]  word_addr_t;	// Upstream word address
	typedef logic [31:0]  word_t;
	typedef logic [127:0] block_t;	// Four words, word 0 in the low bits
	typedef logic [5:0]   tag_t;
	typedef logic [3:0]   index_t;
	typedef logic [1:0]   offset_t;
	typedef logic [1:0]   way_t;
	typedef logic [1:0]   age_t;	// 3 is most recent, 0 is the victim

	localparam int NUM_WAYS        = 4;
	localparam int NUM_SETS        = 2 ** $bits(index_t);
	localparam int WORDS_PER_BLOCK = 2 ** $bits(offset_t);

	// Address layout is tag, index, offset from high to low
	localparam int OFFSET_LSB = 0;
	localparam int INDEX_LSB  = OFFSET_LSB + $bits(offset_t);
	localparam int TAG_LSB    = INDEX_LSB + $bits(index_t);

	// Controller states
	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		WRITE_BACK,
		ALLOCATE,
		RESPOND
	} ctrl_state_t;

endpackage

// File: source/cache_lookup_if.sv
/*
 * Lookup bus shared by the controller, the tag store and the LRU tracker.
 * The controller presents index and tag; the other two answer combinationally.
 */
`timescale 1ns/1ps

interface cache_lookup_if import l2_cache_pkg::*; ();

	index_t index;
	tag_t   tag;
	logic   access_valid;	// Promote hit_way_sel in the LRU order
	way_t   hit_way_sel;
	logic   fill_valid;	// Install tag into the victim way

	logic   hit;
	way_t   hit_way;
	logic   victim_dirty;
	tag_t   victim_tag;
	way_t   victim_way;

	modport controller (
		output index, tag, access_valid, hit_way_sel, fill_valid,
		input  hit, hit_way, victim_dirty, victim_tag, victim_way
	);

	modport tags (
		input  index, tag, fill_valid, victim_way,
		output hit, hit_way, victim_dirty, victim_tag
	);

	modport lru (
		input  index, access_valid, hit_way_sel,
		output victim_way
	);

endinterface

// File: source/tag_store.sv
/*
 * Tag, valid and dirty bits for every way of every set.
 * Hit and victim status are combinational from the lookup bus.
 */
`timescale 1ns/1ps

module tag_store import l2_cache_pkg::*; (
	input logic clk,
	input logic reset,
	cache_lookup_if.tags lookup,
	input logic set_dirty,	// Write hit on the hit way
	input logic clear_dirty	// Victim has been written back
);

	tag_t tag_mem [NUM_SETS][NUM_WAYS];
	logic valid   [NUM_SETS][NUM_WAYS];
	logic dirty   [NUM_SETS][NUM_WAYS];

	// Compare the tag against all ways of the set
	always_comb begin
		lookup.hit = 1'b0;
		lookup.hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (valid[lookup.index][w] && tag_mem[lookup.index][w] == lookup.tag) begin
				lookup.hit = 1'b1;
				lookup.hit_way = way_t'(w);
			end
		end
	end

	assign lookup.victim_dirty = dirty[lookup.index][lookup.victim_way];
	assign lookup.victim_tag = tag_mem[lookup.index][lookup.victim_way];	// For write-back address

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					valid[s][w] <= 1'b0;
					dirty[s][w] <= 1'b0;
				end
			end
		end else begin
			if (lookup.fill_valid) begin
				valid[lookup.index][lookup.victim_way] <= 1'b1;
				dirty[lookup.index][lookup.victim_way] <= 1'b0;	// Fresh copy of memory
			end else if (set_dirty) begin
				dirty[lookup.index][lookup.hit_way] <= 1'b1;
			end else if (clear_dirty) begin
				dirty[lookup.index][lookup.victim_way] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lookup.fill_valid)
			tag_mem[lookup.index][lookup.victim_way] <= lookup.tag;
	end

endmodule

// File: source/lru_tracker.sv
/*
 * True LRU by per-set age counters, one per way.
 * The way at age 0 is offered as victim; an access moves its way to age 3.
 */
`timescale 1ns/1ps

module lru_tracker import l2_cache_pkg::*; (
	input logic clk,
	input logic reset,
	cache_lookup_if.lru lookup
);

	age_t age [NUM_SETS][NUM_WAYS];
	age_t sel_age;	// Age of the way being accessed

	assign sel_age = age[lookup.index][lookup.hit_way_sel];

	// Ages in a set are always a permutation of 0..3
	always_comb begin
		lookup.victim_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (age[lookup.index][w] == '0)
				lookup.victim_way = way_t'(w);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++)
					age[s][w] <= age_t'(w);	// Way 0 is evicted first
			end
		end else if (lookup.access_valid) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (way_t'(w) == lookup.hit_way_sel)
					age[lookup.index][w] <= '1;
				else if (age[lookup.index][w] > sel_age)
					age[lookup.index][w] <= age[lookup.index][w] - 1'b1;
			end
		end
	end

endmodule

// File: source/data_store.sv
/*
 * Block data for all sets and ways, kept as words.
 * Single-word merge on a write hit, whole-block replace on a fill.
 */
`timescale 1ns/1ps

module data_store import l2_cache_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  way_t    way,
	input  index_t  index,
	input  offset_t offset,
	input  logic    word_we,
	input  word_t   word_wdata,
	input  logic    fill_en,
	input  block_t  fill_data,
	output block_t  block_rdata,	// Whole block, used for write-back
	output word_t   word_rdata
);

	word_t mem [NUM_SETS][NUM_WAYS][WORDS_PER_BLOCK];

	always_comb begin
		for (int i = 0; i < WORDS_PER_BLOCK; i++)
			block_rdata[i*$bits(word_t) +: $bits(word_t)] = mem[index][way][i];
	end

	assign word_rdata = mem[index][way][offset];

	// No writes land while reset is held
	always_ff @(posedge clk) begin
		if (!reset) begin
			if (fill_en) begin
				for (int i = 0; i < WORDS_PER_BLOCK; i++)
					mem[index][way][i] <= fill_data[i*$bits(word_t) +: $bits(word_t)];
			end else if (word_we) begin
				mem[index][way][offset] <= word_wdata;
			end
		end
	end

endmodule

// File: source/cache_controller.sv
/*
 * Cache control FSM: compare, write-back of a dirty victim, allocate, respond.
 * Holds one latched CPU request and drives both request/ack handshakes.
 */
`timescale 1ns/1ps

module cache_controller import l2_cache_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cpu_req,
	input  logic       cpu_we,
	input  word_addr_t cpu_addr,
	input  word_t      cpu_wdata,
	output logic       cpu_ack,
	output logic       cpu_hit,
	output word_t      cpu_rdata,
	output logic       mem_req,
	output logic       mem_we,
	output logic [$bits(tag_t)+$bits(index_t)-1:0] mem_addr,
	output block_t     mem_wdata,
	input  block_t     mem_rdata,
	input  logic       mem_ack,
	cache_lookup_if.controller lookup,
	output way_t       way,
	output index_t     index,
	output offset_t    offset,
	output logic       word_we,
	output word_t      word_wdata,
	output logic       fill_en,
	output block_t     fill_data,
	input  block_t     block_rdata,
	input  word_t      word_rdata,
	output logic       set_dirty,
	output logic       clear_dirty
);

	ctrl_state_t state, next_state;

	logic       req_we;
	word_addr_t req_addr;
	word_t      req_wdata;
	word_t      rdata_q;	// Word returned with cpu_ack
	logic       first_cmp;	// Next compare is the first for this request
	logic       first_hit;
	tag_t       req_tag;

	assign req_tag = req_addr[TAG_LSB +: $bits(tag_t)];
	assign index   = req_addr[INDEX_LSB +: $bits(index_t)];
	assign offset  = req_addr[OFFSET_LSB +: $bits(offset_t)];

	assign lookup.index        = index;
	assign lookup.tag          = req_tag;
	assign lookup.access_valid = (state == COMPARE) && lookup.hit;
	assign lookup.hit_way_sel  = lookup.hit_way;
	assign lookup.fill_valid   = (state == ALLOCATE) && mem_ack;

	// Hit way on a hit, otherwise the victim
	assign way = lookup.hit ? lookup.hit_way : lookup.victim_way;

	assign word_we     = (state == COMPARE) && lookup.hit && req_we;
	assign word_wdata  = req_wdata;
	assign set_dirty   = word_we;
	assign fill_en     = lookup.fill_valid;
	assign fill_data   = mem_rdata;
	assign clear_dirty = (state == WRITE_BACK) && mem_ack;

	// Downstream request held for the whole state
	assign mem_req   = (state == WRITE_BACK) || (state == ALLOCATE);
	assign mem_we    = (state == WRITE_BACK);
	assign mem_addr  = (state == WRITE_BACK) ? {lookup.victim_tag, index} : {req_tag, index};
	assign mem_wdata = block_rdata;

	assign cpu_ack   = (state == RESPOND);
	assign cpu_hit   = first_hit;
	assign cpu_rdata = rdata_q;

	always_comb begin
		next_state = state;
		case (state)
			IDLE:       if (cpu_req) next_state = COMPARE;
			COMPARE: begin
				if (lookup.hit)
					next_state = RESPOND;
				else if (lookup.victim_dirty)
					next_state = WRITE_BACK;
				else
					next_state = ALLOCATE;
			end
			WRITE_BACK: if (mem_ack) next_state = ALLOCATE;
			ALLOCATE:   if (mem_ack) next_state = COMPARE;	// Compare again, now hits
			RESPOND:    next_state = IDLE;
			default:    next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			first_cmp <= 1'b0;
			first_hit <= 1'b0;
		end else begin
			state <= next_state;
			if (state == IDLE && cpu_req)
				first_cmp <= 1'b1;
			else if (state == COMPARE) begin
				first_cmp <= 1'b0;
				if (first_cmp)
					first_hit <= lookup.hit;
			end
		end
	end

	// Request payload and response word
	always_ff @(posedge clk) begin
		if (state == IDLE && cpu_req) begin
			req_we <= cpu_we;
			req_addr <= cpu_addr;
			req_wdata <= cpu_wdata;
		end
		if (state == COMPARE && lookup.hit)
			rdata_q <= req_we ? req_wdata : word_rdata;
	end

endmodule

// File: source/l2_cache_top.sv
/*
 * Top level of the 4-way write-back L2 cache.
 * Plain upstream word port and downstream block port; connects the four blocks.
 */
`timescale 1ns/1ps

module l2_cache_top import l2_cache_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cpu_req,
	input  logic       cpu_we,
	input  word_addr_t cpu_addr,
	input  word_t      cpu_wdata,
	output logic       cpu_ack,
	output logic       cpu_hit,
	output word_t      cpu_rdata,
	output logic       mem_req,
	output logic       mem_we,
	output logic [$bits(tag_t)+$bits(index_t)-1:0] mem_addr,	// Block address
	output block_t     mem_wdata,
	input  block_t     mem_rdata,
	input  logic       mem_ack
);

	cache_lookup_if lookup_bus ();

	way_t    ds_way;
	index_t  ds_index;
	offset_t ds_offset;
	logic    ds_word_we;
	word_t   ds_word_wdata;
	logic    ds_fill_en;
	block_t  ds_fill_data;
	block_t  ds_block_rdata;
	word_t   ds_word_rdata;
	logic    set_dirty;
	logic    clear_dirty;

	cache_controller controller_inst (
		.clk, .reset,
		.cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_ack, .cpu_hit, .cpu_rdata,
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack,
		.lookup      (lookup_bus.controller),
		.way         (ds_way),
		.index       (ds_index),
		.offset      (ds_offset),
		.word_we     (ds_word_we),
		.word_wdata  (ds_word_wdata),
		.fill_en     (ds_fill_en),
		.fill_data   (ds_fill_data),
		.block_rdata (ds_block_rdata),
		.word_rdata  (ds_word_rdata),
		.set_dirty, .clear_dirty
	);

	tag_store tag_store_inst (.clk, .reset, .lookup(lookup_bus.tags), .set_dirty, .clear_dirty);

	lru_tracker lru_tracker_inst (.clk, .reset, .lookup(lookup_bus.lru));

	data_store data_store_inst (
		.clk, .reset,
		.way (ds_way), .index (ds_index), .offset (ds_offset),
		.word_we (ds_word_we), .word_wdata (ds_word_wdata),
		.fill_en (ds_fill_en), .fill_data (ds_fill_data),
		.block_rdata (ds_block_rdata), .word_rdata (ds_word_rdata)
	);

endmodule

// File: testbench/lower_memory_model.sv
/*
 * Behavioral next-level memory for the L2 cache testbench.
 * Holds one block per block address and answers each request after 0 to 5 idle cycles.
 */
`timescale 1ns/1ps

module lower_memory_model import l2_cache_pkg::*; #(
	parameter int SEED = 1
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   mem_req,
	input  logic   mem_we,
	input  logic [$bits(tag_t)+$bits(index_t)-1:0] mem_addr,
	input  block_t mem_wdata,
	output block_t mem_rdata,
	output logic   mem_ack
);

	localparam int NUM_BLOCKS = 2 ** ($bits(tag_t) + $bits(index_t));

	word_t blocks [NUM_BLOCKS][WORDS_PER_BLOCK];
	int    seed = SEED;
	logic  busy;
	int    delay;	// Idle cycles left before the ack

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			delay <= 0;
			mem_ack <= 1'b0;
			mem_rdata <= '0;
			// Word content from the full word address
			for (int b = 0; b < NUM_BLOCKS; b++) begin
				for (int i = 0; i < WORDS_PER_BLOCK; i++)
					blocks[b][i] <= (32'(b * WORDS_PER_BLOCK + i) * 32'h9E37_79B1) ^ 32'hA5C3_0F69;
			end
		end else begin
			mem_ack <= 1'b0;
			if (!busy) begin
				if (mem_req && !mem_ack) begin	// Request still held in the ack cycle is the old one
					busy <= 1'b1;
					delay <= $unsigned($random(seed)) % 6;
				end
			end else if (delay == 0) begin
				busy <= 1'b0;
				mem_ack <= 1'b1;
				if (mem_we) begin
					for (int i = 0; i < WORDS_PER_BLOCK; i++)
						blocks[mem_addr][i] <= mem_wdata[i*$bits(word_t) +: $bits(word_t)];
				end else begin
					for (int i = 0; i < WORDS_PER_BLOCK; i++)
						mem_rdata[i*$bits(word_t) +: $bits(word_t)] <= blocks[mem_addr][i];
				end
			end else begin
				delay <= delay - 1;
			end
		end
	end

endmodule

// File: testbench/tb_l2_cache.sv
/*
 * Testbench for the L2 cache: directed and random word accesses.
 * Each cpu_ack is compared against a reference cache model with a shadow memory.
 */
`timescale 1ns/1ps

module tb_l2_cache import l2_cache_pkg::*; ();

	localparam int NUM_REQUESTS = 423;
	localparam int MEM_WORDS = 2 ** $bits(word_addr_t);

	logic       clk = 1'b0;
	logic       reset;
	logic       cpu_req, cpu_we, cpu_ack, cpu_hit;
	word_addr_t cpu_addr;
	word_t      cpu_wdata, cpu_rdata;
	logic       mem_req, mem_we, mem_ack;
	logic [$bits(tag_t)+$bits(index_t)-1:0] mem_addr;
	block_t     mem_wdata, mem_rdata;

	int    seed = 62871;
	string test_name = "reset";

	// Reference cache state
	tag_t  ref_tag   [NUM_SETS][NUM_WAYS];
	logic  ref_valid [NUM_SETS][NUM_WAYS];
	age_t  ref_age   [NUM_SETS][NUM_WAYS];
	word_t shadow    [MEM_WORDS];

	word_t exp_rdata_q [$];
	logic  exp_hit_q   [$];
	word_t exp_rdata;
	logic  exp_hit;

	always #10 clk = ~clk;

	l2_cache_top l2_cache_top_inst (
		.clk, .reset,
		.cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_ack, .cpu_hit, .cpu_rdata,
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
	);

	lower_memory_model #(.SEED(62871)) memory_inst (
		.clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
	);

	function automatic word_addr_t make_addr(int tag, int idx, int off);
		return {tag_t'(tag), index_t'(idx), offset_t'(off)};
	endfunction

	task automatic reset_model();
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_age[s][w] = age_t'(w);	// Way 0 leaves first
			end
		end
		for (int a = 0; a < MEM_WORDS; a++)
			shadow[a] = (32'(a) * 32'h9E37_79B1) ^ 32'hA5C3_0F69;	// Same fill as the memory model
	endtask

	// Expected word and hit flag; also advances the model
	function automatic word_t predict_access(input logic we, input word_addr_t addr,
			input word_t wdata, output logic hit);
		index_t idx;
		tag_t   tag;
		way_t   way;
		age_t   old_age;
		idx = addr[INDEX_LSB +: $bits(index_t)];
		tag = addr[TAG_LSB +: $bits(tag_t)];
		hit = 1'b0;
		way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		if (!hit) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (ref_age[idx][w] == 0)
					way = way_t'(w);	// Oldest way is replaced
			end
			ref_tag[idx][way] = tag;
			ref_valid[idx][way] = 1'b1;
		end
		old_age = ref_age[idx][way];
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_age[idx][w] > old_age)
				ref_age[idx][w] = ref_age[idx][w] - 2'd1;
		end
		ref_age[idx][way] = 2'd3;
		if (we)
			shadow[addr] = wdata;
		return shadow[addr];
	endfunction

	// One request, held until cpu_ack
	task automatic do_access(input logic we, input word_addr_t addr, input word_t wdata);
		logic  hit;
		word_t rdata;
		@(posedge clk);
		cpu_req <= 1'b1;
		cpu_we <= we;
		cpu_addr <= addr;
		cpu_wdata <= wdata;
		rdata = predict_access(we, addr, wdata, hit);
		exp_rdata_q.push_back(rdata);
		exp_hit_q.push_back(hit);
		do
			@(posedge clk);
		while (!cpu_ack);
		cpu_req <= 1'b0;
	endtask

	task automatic random_traffic(input int count);
		int r;
		for (int i = 0; i < count; i++) begin
			r = $random(seed);
			// Eight tags over four sets keeps evictions frequent
			do_access(r[12], make_addr(r[2:0], r[5:4], r[9:8]), $random(seed));
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			assert (!mem_we || mem_req)
			else begin
				$display("mem_we is high without mem_req during %s", test_name);
				$display("Test failed");
				$fatal(1);
			end
			if (cpu_ack) begin
				assert (exp_rdata_q.size() > 0)
				else begin
					$display("cpu_ack arrived with no request outstanding during %s", test_name);
					$display("Test failed");
					$fatal(1);
				end
				exp_rdata = exp_rdata_q.pop_front();
				exp_hit = exp_hit_q.pop_front();
				assert (cpu_rdata === exp_rdata)
				else begin
					$display("mismatch %s cpu_rdata expected %h actual %h",
						test_name, exp_rdata, cpu_rdata);
					$display("Test failed");
					$fatal(1);
				end
				assert (cpu_hit === exp_hit)
				else begin
					$display("mismatch %s cpu_hit expected %b actual %b", test_name, exp_hit, cpu_hit);
					$display("Test failed");
					$fatal(1);
				end
			end
		end
	end

	// Watchdog sized by the worst miss path per request
	initial begin
		repeat (NUM_REQUESTS * 40 + 200) @(posedge clk);
		$display("Timeout after %0d cycles, the cache stopped answering during %s",
			NUM_REQUESTS * 40 + 200, test_name);
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		reset = 1'b1;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		reset_model();
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		@(posedge clk);
		assert (!cpu_ack && !mem_req && !mem_we)
		else begin
			$display("cpu_ack, mem_req or mem_we is high right after reset");
			$display("Test failed");
			$fatal(1);
		end

		test_name = "read_miss_then_hit";
		do_access(1'b0, make_addr(0, 5, 0), '0);
		do_access(1'b0, make_addr(0, 5, 0), '0);

		test_name = "write_then_read";
		do_access(1'b1, make_addr(0, 5, 1), 32'hCAFE_0001);
		do_access(1'b0, make_addr(0, 5, 1), '0);
		do_access(1'b0, make_addr(0, 5, 0), '0);	// Neighbors keep their words
		do_access(1'b0, make_addr(0, 5, 2), '0);

		test_name = "lru_eviction";
		for (int t = 1; t <= 4; t++)
			do_access(1'b0, make_addr(t, 9, 0), '0);
		do_access(1'b0, make_addr(2, 9, 0), '0);	// Tag 1 stays the oldest
		do_access(1'b0, make_addr(5, 9, 0), '0);	// Replaces tag 1
		do_access(1'b0, make_addr(1, 9, 0), '0);	// Replaces tag 3
		do_access(1'b0, make_addr(2, 9, 0), '0);	// Still resident

		test_name = "dirty_write_back";
		for (int t = 1; t <= 4; t++)
			do_access(1'b1, make_addr(t, 12, 1), 32'hD000_0000 + 32'(t));
		for (int t = 5; t <= 8; t++)
			do_access(1'b0, make_addr(t, 12, 3), '0);
		do_access(1'b0, make_addr(1, 12, 1), '0);	// Comes back from the memory model

		test_name = "random_traffic";
		random_traffic(400);

		@(posedge clk);
		if (!cpu_ack && !mem_req) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("The cache did not return to idle after the last response during %s",
				test_name);
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

// File: vlog.f
source/l2_cache_pkg.sv
source/cache_lookup_if.sv
source/tag_store.sv
source/lru_tracker.sv
source/data_store.sv
source/cache_controller.sv
source/l2_cache_top.sv
testbench/lower_memory_model.sv
testbench/tb_l2_cache.sv

// File: run.sh
#!/bin/sh
# Build the L2 cache testbench with Verilator and run it
set -e

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_l2_cache

output=$(./obj_dir/Vtb_l2_cache 2>&1 || true)
echo "$output"

if echo "$output" | grep -qxF "Test completed successfully"; then
	exit 0
else
	exit 1
fi
